/* verilog/keypad_pkg.sv */
`default_nettype none

package keypad_pkg;

  // Key value, row * 4 + col
  typedef logic [3:0] key_val_t;

  // One scan byte, seen whole or as row/col one-hot halves
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0] row;  // One-hot row, upper nibble
      logic [3:0] col;  // One-hot column, lower nibble
    } fields;
  } scan_code_u;

  localparam key_val_t KEY_CLEAR = 4'hE;
  localparam key_val_t KEY_ENTER = 4'hF;  // Digits are 0 through D

  // Segment bits gfedcba, active high
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F,  // 0 1 2 3
    7'h66, 7'h6D, 7'h7D, 7'h07,  // 4 5 6 7
    7'h7F, 7'h6F, 7'h77, 7'h7C,  // 8 9 A b
    7'h39, 7'h5E, 7'h79, 7'h71   // C d E F
  };

  // Row and column index to key value
  function automatic key_val_t key_map(input logic [1:0] row_idx,
                                       input logic [1:0] col_idx);
    return key_val_t'({row_idx, col_idx});  // Row times four plus column
  endfunction

endpackage

`default_nettype wire

/* verilog/digit_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface digit_if import keypad_pkg::*; #(
  parameter int DIGITS = 4
);

  localparam int CNT_W = $clog2(DIGITS + 1);

  logic                shift_en;  // Push digit in at low nibble
  logic                clear;     // Empty the buffer
  key_val_t            digit;
  logic [4*DIGITS-1:0] value;     // Newest digit in [3:0]
  logic [CNT_W-1:0]    count;     // Digits held, 0..DIGITS

  modport ctrl   (output shift_en, clear, digit, input count);
  modport buffer (input shift_en, clear, digit, output value, count);
  modport view   (input value, count);  // Display side, read only

endinterface

`default_nettype wire

/* verilog/keypad_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner import keypad_pkg::*; #(
  parameter int SETTLE_CYCLES = 4
) (
  input  logic       clk,
  input  logic       nRst,
  input  logic [3:0] rows,
  output logic [3:0] cols,
  output logic       key_valid,
  output key_val_t   key_val,
  output scan_code_u key_code
);

  localparam int CNT_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;

  logic [CNT_W-1:0] dwell_cnt;
  logic             dwell_end;  // Last cycle on this column
  logic [3:0]       row_meta;
  logic [3:0]       row_sync;
  logic [3:0]       row_first;  // Lowest set row only
  logic             row_any;
  logic             scan_hit;   // Something seen this scan so far
  logic             held;       // Key still down since last report
  logic             press;
  scan_code_u       code_next;

  // One-hot to index, lowest bit wins
  function automatic logic [1:0] onehot_idx(input logic [3:0] oh);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (oh[i]) idx = 2'(i);
    end
    return idx;
  endfunction

  assign dwell_end = (dwell_cnt == CNT_W'(SETTLE_CYCLES - 1));

  // Column drive, one dwell per column
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      dwell_cnt <= '0;
      cols      <= 4'b0001;
    end else if (dwell_end) begin
      dwell_cnt <= '0;
      cols      <= {cols[2:0], cols[3]};  // Rotate toward col 3
    end else begin
      dwell_cnt <= dwell_cnt + 1'b1;
    end
  end

  // Two-flop row synchronizer
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_meta <= '0;
      row_sync <= '0;
    end else begin
      row_meta <= rows;
      row_sync <= row_meta;
    end
  end

  assign row_any   = |row_sync;
  assign row_first = row_sync & (~row_sync + 4'd1);  // Isolate lowest set bit
  assign press     = dwell_end && row_any && !held;

  always_comb begin
    code_next.fields.row = row_first;
    code_next.fields.col = cols;
  end

  // Press and release tracking
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      held      <= 1'b0;
      scan_hit  <= 1'b0;
      key_valid <= 1'b0;
    end else begin
      key_valid <= press;  // One-cycle pulse
      if (dwell_end) begin
        if (row_any) begin
          held <= 1'b1;
        end else if (cols[3] && !scan_hit) begin
          held <= 1'b0;  // Whole scan empty, key released
        end
        scan_hit <= cols[3] ? 1'b0 : (scan_hit | row_any);
      end
    end
  end

  // Code and value latched with the pulse
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      key_val  <= '0;
      key_code <= '0;
    end else if (press) begin
      key_val  <= key_map(onehot_idx(row_first), onehot_idx(cols));
      key_code <= code_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/entry_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module entry_ctrl import keypad_pkg::*; (
  input  logic         clk,
  input  logic         nRst,
  input  logic         key_valid,
  input  key_val_t     key_val,
  input  logic         ack,
  output logic         req,
  digit_if.ctrl        buf_port
);

  localparam int DIGITS = buf_port.DIGITS;

  // FSM states
  localparam logic [1:0] IDLE      = 2'd0;
  localparam logic [1:0] REQ       = 2'd1;
  localparam logic [1:0] WAIT_DROP = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       take_key;   // Key accepted only when idle
  logic       is_digit;
  logic       has_room;
  logic       has_any;

  assign take_key = (state == IDLE) && key_valid;
  assign is_digit = (key_val < KEY_CLEAR);           // 0..D
  assign has_room = (int'(buf_port.count) < DIGITS);
  assign has_any  = (buf_port.count != '0);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (take_key && (key_val == KEY_ENTER) && has_any) begin
          state_next = REQ;  // Empty enter ignored
        end
      end
      REQ:       if (ack) state_next = WAIT_DROP;
      WAIT_DROP: if (!ack) state_next = IDLE;   // Host done
      default:   state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign req = (state == REQ);  // Drops once ack seen

  // Buffer control, full buffer drops digits
  assign buf_port.shift_en = take_key && is_digit && has_room;
  assign buf_port.digit    = key_val;
  assign buf_port.clear    = (take_key && (key_val == KEY_CLEAR))
                           || ((state == WAIT_DROP) && !ack);  // Handshake complete

endmodule

`default_nettype wire

/* verilog/digit_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_buffer #(
  parameter int DIGITS = 4
) (
  input  logic     clk,
  input  logic     nRst,
  digit_if.buffer  buf_port
);

  localparam int CNT_W = $clog2(DIGITS + 1);

  logic [4*DIGITS-1:0] digits_q;
  logic [CNT_W-1:0]    count_q;
  logic                not_full;

  assign not_full = (count_q < CNT_W'(DIGITS));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      digits_q <= '0;
      count_q  <= '0;
    end else if (buf_port.clear) begin
      digits_q <= '0;  // Contents and count both
      count_q  <= '0;
    end else if (buf_port.shift_en) begin
      // Older digits move up one nibble
      digits_q <= {digits_q[4*DIGITS-5:0], buf_port.digit};
      if (not_full) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign buf_port.value = digits_q;
  assign buf_port.count = count_q;

endmodule

`default_nettype wire

/* verilog/seg_display.sv */
`timescale 1ns/100ps
`default_nettype none

module seg_display import keypad_pkg::*; #(
  parameter int DIGITS = 4
) (
  digit_if.view              disp_port,
  output logic [7*DIGITS-1:0] segs
);

  // Position i shows nibble i, blank from count upward
  always_comb begin
    for (int i = 0; i < DIGITS; i++) begin
      if (i < int'(disp_port.count)) begin
        segs[7*i +: 7] = SEG_TABLE[disp_port.value[4*i +: 4]];
      end else begin
        segs[7*i +: 7] = 7'd0;  // Unused digit dark
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/keypad_entry.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_entry import keypad_pkg::*; #(
  parameter int DIGITS        = 4,
  parameter int SETTLE_CYCLES = 4   // 3 or more for the row sync
) (
  input  logic                clk,
  input  logic                nRst,
  input  logic [3:0]          rows,
  input  logic                ack,
  output logic [3:0]          cols,
  output logic                req,
  output logic [4*DIGITS-1:0] value,
  output logic [7*DIGITS-1:0] segs
);

  logic       key_valid;
  key_val_t   key_val;
  scan_code_u key_code;  // Raw scan byte, for probing

  digit_if #(.DIGITS(DIGITS)) buf_bus ();

  keypad_scanner #(.SETTLE_CYCLES(SETTLE_CYCLES)) scanner_inst (
    .clk       (clk),
    .nRst      (nRst),
    .rows      (rows),
    .cols      (cols),
    .key_valid (key_valid),
    .key_val   (key_val),
    .key_code  (key_code)
  );

  entry_ctrl ctrl_inst (
    .clk       (clk),
    .nRst      (nRst),
    .key_valid (key_valid),
    .key_val   (key_val),
    .ack       (ack),
    .req       (req),
    .buf_port  (buf_bus.ctrl)
  );

  digit_buffer #(.DIGITS(DIGITS)) buffer_inst (
    .clk      (clk),
    .nRst     (nRst),
    .buf_port (buf_bus.buffer)
  );

  seg_display #(.DIGITS(DIGITS)) display_inst (
    .disp_port (buf_bus.view),
    .segs      (segs)
  );

  assign value = buf_bus.value;  // Host reads it while req is high

endmodule

`default_nettype wire

/* verification/keypad_entry_props.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_entry_props #(
  parameter int DIGITS = 4
) (
  input logic                clk,
  input logic                nRst,
  input logic                req,
  input logic                ack,
  input logic [4*DIGITS-1:0] value,
  input logic [3:0]          cols
);

  // Host must see req until it answers
  req_until_ack: assert property (@(posedge clk) disable iff (!nRst)
    req && !ack |=> req) else $error("req dropped before ack");

  value_stable: assert property (@(posedge clk) disable iff (!nRst)
    req |=> !req || $stable(value)) else $error("value moved while req high");

  cols_onehot: assert property (@(posedge clk) disable iff (!nRst)
    $onehot(cols)) else $error("column drive not one-hot");  // Exactly one column low-z

endmodule

`default_nettype wire

/* verification/keypad_entry_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_entry_checker import keypad_pkg::*; #(
  parameter int DIGITS = 4
) (
  input logic                clk,
  input logic                nRst,
  input logic                req,
  input logic                ack,
  input logic [4*DIGITS-1:0] value,
  input logic [7*DIGITS-1:0] segs,
  input logic                key_valid,
  input scan_code_u          key_code
);

  logic [4*DIGITS-1:0] model_val   = '0;    // Newest digit in low nibble
  int                  model_cnt   = 0;
  logic                req_pending = 1'b0;  // Enter taken, req due
  logic                req_q       = 1'b0;
  logic [7:0]          exp_code    = '0;    // Row and column one-hot of last key
  int                  errors      = 0;
  int                  tests       = 0;
  int                  failed      = 0;
  int                  errors_seen = 0;     // Errors before current test

  task automatic mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // Key as the buffer should see it
  task automatic note_key(input key_val_t k);
    exp_code = {4'b0001 << k[3:2], 4'b0001 << k[1:0]};  // Row high, column low
    if (!req && !ack) begin  // Busy host, key ignored
      if (k == KEY_CLEAR) begin
        model_val = '0;
        model_cnt = 0;
      end else if (k == KEY_ENTER) begin
        req_pending = (model_cnt > 0);  // Empty enter does nothing
      end else if (model_cnt < DIGITS) begin
        model_val = {model_val[4*DIGITS-5:0], k};
        model_cnt++;
      end
    end
  endtask

  // Handshake done, buffer empties
  task automatic note_served();
    if (req_pending) begin
      mismatch("enter accepted but no req seen");
    end
    model_val = '0;
    model_cnt = 0;
  endtask

  task automatic check_display();
    logic [7*DIGITS-1:0] exp_segs;
    @(negedge clk);  // Settled
    for (int i = 0; i < DIGITS; i++) begin
      exp_segs[7*i +: 7] = (i < model_cnt) ? SEG_TABLE[model_val[4*i +: 4]] : 7'd0;
    end
    if (segs !== exp_segs) begin
      mismatch($sformatf("segs %h, expected %h", segs, exp_segs));
    end
  endtask

  // Value sampled on the req rise
  always @(negedge clk) begin
    if (nRst === 1'b1 && req === 1'b1 && req_q !== 1'b1) begin
      if (!req_pending) begin
        mismatch("req raised with nothing to send");
      end else if (value !== model_val) begin
        mismatch($sformatf("value %h, expected %h", value, model_val));
      end
      req_pending = 1'b0;
    end
    req_q = req;
  end

  // Scan byte reported with each key
  always @(negedge clk) begin
    if (nRst === 1'b1 && key_valid === 1'b1 && key_code.raw !== exp_code) begin
      mismatch($sformatf("scan code %h, expected %h", key_code.raw, exp_code));
    end
  end

  task automatic end_test(input string name);
    tests++;
    if (errors != errors_seen) failed++;
    $display("test %0d %s: %s", tests, name, (errors == errors_seen) ? "ok" : "failed");
    errors_seen = errors;
  endtask

  task automatic print_counts();
    $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
  endtask

endmodule

`default_nettype wire

/* verification/keypad_entry_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module keypad_entry_tb import keypad_pkg::*; #(
  parameter int DIGITS        = 4,
  parameter int SETTLE_CYCLES = 4
);

  localparam int SCAN = 4 * SETTLE_CYCLES;  // Clocks per full sweep

  logic clk, nRst, ack, req;
  logic [3:0] rows, cols;
  logic [4*DIGITS-1:0] value;
  logic [7*DIGITS-1:0] segs;
  logic key_down;  // Keypad model
  logic [1:0] key_row, key_col;
  logic [31:0] seed;

  keypad_entry #(.DIGITS(DIGITS), .SETTLE_CYCLES(SETTLE_CYCLES)) keypad_entry_inst (.*);
  keypad_entry_checker #(.DIGITS(DIGITS)) checker_inst (
    .*,
    .key_valid (keypad_entry_inst.key_valid),
    .key_code  (keypad_entry_inst.key_code)
  );
  bind keypad_entry keypad_entry_props #(.DIGITS(DIGITS)) props_inst (.*);

  assign rows = (key_down && cols[key_col]) ? (4'b0001 << key_row) : 4'b0000;  // Switch closed

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int unsigned lcg_pick(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % n;  // Low bits cycle too fast
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_req(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (req !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (req !== level) begin
      $display("Timed out after %0d cycles waiting for %s", limit, what);
      $display("** FAIL **");
      $finish;
    end
  endtask

  // Hold six sweeps, release six
  task automatic press_key(input key_val_t k);
    checker_inst.note_key(k);
    key_row  <= k[3:2];  // Value is row * 4 + column
    key_col  <= k[1:0];
    key_down <= 1'b1;
    wait_cycles(6 * SCAN);
    key_down <= 1'b0;
    wait_cycles(6 * SCAN);
    checker_inst.check_display();
    wait_cycles(1);  // Back on a rising edge
  endtask

  task automatic random_digits(input int unsigned n);
    repeat (n) press_key(key_val_t'(lcg_pick(14)));  // 0..D
  endtask

  // Enter, then act as host; optional key while ack high
  task automatic enter_and_serve(input logic busy_key);
    checker_inst.note_key(KEY_ENTER);
    {key_row, key_col, key_down} <= {2'd3, 2'd3, 1'b1};
    wait_req(1'b1, 4 * SCAN, "req after enter");
    wait_cycles(1 + lcg_pick(8));
    ack      <= 1'b1;
    key_down <= 1'b0;
    wait_cycles(6 * SCAN);
    if (busy_key) press_key(key_val_t'(lcg_pick(14)));
    wait_req(1'b0, 4, "req to drop after ack");
    ack <= 1'b0;
    wait_cycles(2);
    checker_inst.note_served();
    checker_inst.check_display();  // Blank, count back to 0
    wait_cycles(1);
  endtask

  initial begin
    {nRst, ack, key_down, key_row, key_col} = '0;
    seed = 32'hc443c081;
    wait_cycles(8);
    nRst <= 1'b1;
    wait_cycles(2);
    repeat (3) begin
      random_digits(1 + lcg_pick(DIGITS));
      enter_and_serve(1'b0);
    end
    checker_inst.end_test("digit entry and enter");
    random_digits(DIGITS);  // Display checked after each
    enter_and_serve(1'b0);
    checker_inst.end_test("display");
    random_digits(2);
    press_key(KEY_CLEAR);
    random_digits(1);
    enter_and_serve(1'b0);
    checker_inst.end_test("clear");
    press_key(KEY_ENTER);  // No req allowed across 12 sweeps
    random_digits(DIGITS + 2);
    enter_and_serve(1'b0);
    checker_inst.end_test("overflow and empty enter");
    random_digits(2);
    enter_and_serve(1'b1);
    checker_inst.end_test("back-pressure");
    checker_inst.print_counts();
    if (checker_inst.errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* keypad_entry.f */
verilog/keypad_pkg.sv
verilog/digit_if.sv
verilog/keypad_scanner.sv
verilog/entry_ctrl.sv
verilog/digit_buffer.sv
verilog/seg_display.sv
verilog/keypad_entry.sv
verification/keypad_entry_props.sv
verification/keypad_entry_checker.sv
verification/keypad_entry_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module keypad_entry_tb -f keypad_entry.f -Mdir obj_dir
	./obj_dir/Vkeypad_entry_tb | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
